// File: filelist.f
+incdir+tb
hw/cmd_seq_pkg.sv
hw/cmd_seq_axil_regs.sv
hw/cmd_seq_mem.sv
hw/cmd_seq_ctrl.sv
hw/cmd_line_encoder.sv
hw/cmd_seq_top.sv
tb/cmd_seq_tb.sv

// File: hw/cmd_line_encoder.sv
// line mode and pulse disable are read live, keep them stable during a run; Manchester takes 2 cycles per bit
`default_nettype none

module cmd_line_encoder
    import cmd_seq_pkg::*;
(
    input  wire             CMD_CLK_IN,
    input  wire             RST_CMD_CLK,
    input  wire line_mode_e line_mode,
    input  wire             dis_start_pulse,
    input  wire cmd_bit_t   bit_in,
    input  wire             bit_valid,
    output logic            bit_ready,
    output logic            cmd_data,
    output logic            cmd_active,
    output logic            cmd_start_flag
);

    logic phase;       // second half-bit pending
    logic cur_bit;
    logic cur_first;
    logic xfer;
    logic manch;

    assign manch     = (line_mode == LINE_MAN_IEEE) || (line_mode == LINE_MAN_THOMAS);
    assign bit_ready = !phase;
    assign xfer      = bit_valid && bit_ready;

    always_ff @(posedge CMD_CLK_IN) begin
        if (RST_CMD_CLK) begin
            phase          <= 1'b0;
            cmd_data       <= 1'b0;
            cmd_active     <= 1'b0;
            cmd_start_flag <= 1'b0;
        end else begin
            phase      <= xfer && manch;
            cmd_active <= xfer || phase;
            if (xfer) begin
                cmd_data       <= (line_mode == LINE_MAN_IEEE) ? !bit_in.data : bit_in.data;
                cmd_start_flag <= bit_in.body_first && !dis_start_pulse;
            end else if (phase) begin
                cmd_data       <= (line_mode == LINE_MAN_THOMAS) ? !cur_bit : cur_bit;
                cmd_start_flag <= cur_first && !dis_start_pulse;  // pulse covers both halves
            end else begin
                cmd_data       <= 1'b0;   // idle low
                cmd_start_flag <= 1'b0;
            end
        end
    end

    always_ff @(posedge CMD_CLK_IN) begin
        if (xfer) begin
            cur_bit   <= bit_in.data;
            cur_first <= bit_in.body_first;
        end
    end

endmodule

`default_nettype wire

// File: hw/cmd_seq_axil_regs.sv
// AXI4-Lite slave, single outstanding write and read; memory window is write-only and reads 0
`default_nettype none

module cmd_seq_axil_regs
    import cmd_seq_pkg::*;
(
    input  wire                CMD_CLK_IN,
    input  wire                RST_CMD_CLK,
    input  wire [AXIL_AW-1:0]  s_axil_awaddr,
    input  wire                s_axil_awvalid,
    output logic               s_axil_awready,
    input  wire [31:0]         s_axil_wdata,
    input  wire [3:0]          s_axil_wstrb,
    input  wire                s_axil_wvalid,
    output logic               s_axil_wready,
    output logic [1:0]         s_axil_bresp,
    output logic               s_axil_bvalid,
    input  wire                s_axil_bready,
    input  wire [AXIL_AW-1:0]  s_axil_araddr,
    input  wire                s_axil_arvalid,
    output logic               s_axil_arready,
    output logic [31:0]        s_axil_rdata,
    output logic [1:0]         s_axil_rresp,
    output logic               s_axil_rvalid,
    input  wire                s_axil_rready,
    input  wire                busy,
    output seq_conf_t          conf,
    output logic               start_req,
    output logic               soft_rst,
    output mem_wr_t            mem_wr
);

    logic               wr_fire;
    logic               rd_fire;
    logic [AXIL_AW-1:0] wr_addr;
    logic [AXIL_AW-1:0] rd_addr;
    logic               ctrl_wr;
    logic               conf_rst;
    logic               finish;
    logic               busy_q;
    logic [31:0]        rd_word;
    logic               rd_err;

    function automatic logic in_mem_win(input logic [AXIL_AW-1:0] addr);
        return (addr >= MEM_BASE) && (addr < MEM_BASE + CMD_MEM_BYTES);
    endfunction

    // address and data are taken in the same cycle
    assign wr_fire        = s_axil_awvalid && s_axil_wvalid && !s_axil_bvalid;
    assign s_axil_awready = wr_fire;
    assign s_axil_wready  = wr_fire;
    assign s_axil_bresp   = AXI_RESP_OKAY;

    assign rd_fire        = s_axil_arvalid && s_axil_arready;
    assign s_axil_arready = !s_axil_rvalid;

    assign wr_addr  = {s_axil_awaddr[AXIL_AW-1:2], 2'b00};
    assign rd_addr  = {s_axil_araddr[AXIL_AW-1:2], 2'b00};
    assign ctrl_wr  = wr_fire && (wr_addr == REG_CTRL);
    assign conf_rst = RST_CMD_CLK || soft_rst;

    assign mem_wr = '{
        en:   wr_fire && in_mem_win(wr_addr),
        addr: wr_addr[CMD_MEM_AW+1:2],
        strb: s_axil_wstrb,
        data: s_axil_wdata
    };

    always_ff @(posedge CMD_CLK_IN) begin
        if (RST_CMD_CLK) begin
            s_axil_bvalid <= 1'b0;
            s_axil_rvalid <= 1'b0;
            start_req     <= 1'b0;
            soft_rst      <= 1'b0;
        end else begin
            if (wr_fire)
                s_axil_bvalid <= 1'b1;
            else if (s_axil_bready)
                s_axil_bvalid <= 1'b0;
            if (rd_fire)
                s_axil_rvalid <= 1'b1;
            else if (s_axil_rready)
                s_axil_rvalid <= 1'b0;
            start_req <= ctrl_wr && s_axil_wdata[0];
            soft_rst  <= ctrl_wr && s_axil_wdata[1];
        end
    end

    // config and finish flag, also cleared by soft reset
    always_ff @(posedge CMD_CLK_IN) begin
        if (conf_rst) begin
            conf   <= CONF_DEFAULT;
            finish <= 1'b1;
            busy_q <= 1'b0;
        end else begin
            busy_q <= busy;
            if (wr_fire) begin
                case (wr_addr)
                    REG_CONF: begin
                        conf.en_ext_start    <= s_axil_wdata[0];
                        conf.line_mode       <= line_mode_e'(s_axil_wdata[2:1]);
                        conf.dis_start_pulse <= s_axil_wdata[4];
                    end
                    REG_CMD_SIZE:  conf.cmd_size     <= s_axil_wdata[15:0];
                    REG_REPEAT:    conf.repeat_count <= s_axil_wdata;
                    REG_START_REP: conf.start_rep    <= s_axil_wdata[15:0];
                    REG_STOP_REP:  conf.stop_rep     <= s_axil_wdata[15:0];
                    default: ;
                endcase
            end
            if ((ctrl_wr && s_axil_wdata[0]) || (busy && !busy_q))
                finish <= 1'b0;            // start write or external start
            else if (busy_q && !busy)
                finish <= 1'b1;
        end
    end

    always_comb begin
        rd_word = '0;
        rd_err  = 1'b0;
        case (rd_addr)
            REG_CTRL:      rd_word = {31'd0, finish};
            REG_CONF:      rd_word = {27'd0, conf.dis_start_pulse, 1'b0, conf.line_mode,
                                      conf.en_ext_start};
            REG_CMD_SIZE:  rd_word = {16'd0, conf.cmd_size};
            REG_REPEAT:    rd_word = conf.repeat_count;
            REG_START_REP: rd_word = {16'd0, conf.start_rep};
            REG_STOP_REP:  rd_word = {16'd0, conf.stop_rep};
            default:       rd_err  = !in_mem_win(rd_addr);  // memory window gives zero
        endcase
    end

    always_ff @(posedge CMD_CLK_IN) begin
        if (rd_fire) begin
            s_axil_rdata <= rd_word;
            s_axil_rresp <= rd_err ? AXI_RESP_SLVERR : AXI_RESP_OKAY;
        end
    end

endmodule

`default_nettype wire

// File: hw/cmd_seq_ctrl.sv
// needs cmd_size >= 1, start_rep + stop_rep < cmd_size, repeat_count >= 1; starts while busy are dropped
`default_nettype none

module cmd_seq_ctrl
    import cmd_seq_pkg::*;
(
    input  wire                   CMD_CLK_IN,
    input  wire                   RST_CMD_CLK,
    input  wire seq_conf_t        conf,
    input  wire                   start_req,
    input  wire                   ext_start_flag,
    input  wire [31:0]            rd_data,
    input  wire                   bit_ready,
    output logic [CMD_MEM_AW-1:0] rd_addr,
    output cmd_bit_t              bit_out,
    output logic                  bit_valid,
    output logic                  busy,
    output logic                  cmd_ready
);

    typedef enum logic {
        IDLE,
        RUN
    } state_e;

    state_e                state;
    logic                  issuing;     // bits left to fetch
    logic [15:0]           idx;
    logic [31:0]           rep;         // current body pass, from 1
    logic                  s1_valid;    // memory read in flight
    logic [4:0]            s1_pos;
    logic                  s1_first;
    logic [CMD_MEM_AW-1:0] s1_addr;

    logic        start_go;
    logic        adv;
    logic        jump;
    logic        drained;
    logic [15:0] body_last;
    logic [15:0] last_idx;

    assign start_go  = (state == IDLE) && (start_req || (conf.en_ext_start && ext_start_flag));
    assign adv       = !bit_valid || bit_ready;           // output stage free or handing over
    assign body_last = conf.cmd_size - conf.stop_rep - 16'd1;
    assign last_idx  = conf.cmd_size - 16'd1;
    assign jump      = (idx == body_last) && (rep != conf.repeat_count);
    assign busy      = !cmd_ready;

    // encoder shows its last symbol once nothing is left here and it is ready again
    assign drained = !issuing && !s1_valid && !bit_valid && bit_ready;

    // a stall re-reads the stage 1 word so rd_data stays valid for it
    assign rd_addr = adv ? idx[CMD_MEM_AW+4:5] : s1_addr;

    always_ff @(posedge CMD_CLK_IN) begin
        if (RST_CMD_CLK) begin
            state     <= IDLE;
            issuing   <= 1'b0;
            idx       <= '0;
            rep       <= '0;
            s1_valid  <= 1'b0;
            bit_valid <= 1'b0;
            cmd_ready <= 1'b1;
        end else if (start_go) begin
            state     <= RUN;
            issuing   <= 1'b1;
            idx       <= '0;
            rep       <= 32'd1;
            s1_valid  <= 1'b0;
            bit_valid <= 1'b0;
            cmd_ready <= 1'b0;
        end else if (state == RUN) begin
            if (adv) begin
                bit_valid <= s1_valid;
                s1_valid  <= issuing;
                if (issuing) begin
                    if (jump) begin
                        idx <= conf.start_rep;     // next body pass
                        rep <= rep + 32'd1;
                    end else if (idx == last_idx) begin
                        issuing <= 1'b0;
                    end else begin
                        idx <= idx + 16'd1;
                    end
                end
            end
            if (drained)
                state <= IDLE;
        end else begin
            cmd_ready <= 1'b1;   // line has been quiet for a cycle
        end
    end

    // fetch pipeline payload
    always_ff @(posedge CMD_CLK_IN) begin
        if (adv) begin
            bit_out.data       <= rd_data[s1_pos];
            bit_out.body_first <= s1_first;
            s1_pos             <= {idx[4:3], ~idx[2:0]};  // lane i/8, MSB first
            s1_first           <= (idx == conf.start_rep);
            s1_addr            <= idx[CMD_MEM_AW+4:5];
        end
    end

endmodule

`default_nettype wire

// File: hw/cmd_seq_mem.sv
// 512 x 32 single-clock RAM, read data one cycle after address, contents kept over reset
`default_nettype none

module cmd_seq_mem
    import cmd_seq_pkg::*;
(
    input  wire                  CMD_CLK_IN,
    input  wire mem_wr_t         mem_wr,
    input  wire [CMD_MEM_AW-1:0] rd_addr,
    output logic [31:0]          rd_data
);

    logic [31:0] mem [CMD_MEM_WORDS];

    // byte lanes, little endian within the word
    always_ff @(posedge CMD_CLK_IN) begin
        if (mem_wr.en) begin
            for (int b = 0; b < 4; b++) begin
                if (mem_wr.strb[b])
                    mem[mem_wr.addr][8*b +: 8] <= mem_wr.data[8*b +: 8];
            end
        end
    end

    always_ff @(posedge CMD_CLK_IN) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// File: hw/cmd_seq_pkg.sv
// shared by bus and sequencer on CMD_CLK_IN; byte offsets on a 13-bit bus, 32-bit aligned only
`default_nettype none

package cmd_seq_pkg;

    localparam int CMD_MEM_BYTES = 2048;
    localparam int CMD_MEM_WORDS = CMD_MEM_BYTES / 4;   // 512 words
    localparam int CMD_MEM_AW    = 9;
    localparam int AXIL_AW       = 13;

    // register map, byte offsets
    localparam logic [AXIL_AW-1:0] REG_CTRL      = 13'h000;  // wr: bit0 start, bit1 soft reset
    localparam logic [AXIL_AW-1:0] REG_CONF      = 13'h004;
    localparam logic [AXIL_AW-1:0] REG_CMD_SIZE  = 13'h008;
    localparam logic [AXIL_AW-1:0] REG_REPEAT    = 13'h00C;
    localparam logic [AXIL_AW-1:0] REG_START_REP = 13'h010;
    localparam logic [AXIL_AW-1:0] REG_STOP_REP  = 13'h014;
    localparam logic [AXIL_AW-1:0] MEM_BASE      = 13'h1000; // write-only window

    localparam logic [1:0] AXI_RESP_OKAY   = 2'b00;
    localparam logic [1:0] AXI_RESP_SLVERR = 2'b10;

    // value 1 is reserved, encoder treats it as NRZ
    typedef enum logic [1:0] {
        LINE_NRZ        = 2'd0,
        LINE_MAN_IEEE   = 2'd2,
        LINE_MAN_THOMAS = 2'd3
    } line_mode_e;

    typedef struct packed {
        logic [15:0] cmd_size;
        logic [31:0] repeat_count;
        logic [15:0] start_rep;
        logic [15:0] stop_rep;
        logic        en_ext_start;
        logic        dis_start_pulse;
        line_mode_e  line_mode;
    } seq_conf_t;

    localparam seq_conf_t CONF_DEFAULT = '{
        cmd_size:        16'd0,
        repeat_count:    32'd1,
        start_rep:       16'd0,
        stop_rep:        16'd0,
        en_ext_start:    1'b0,
        dis_start_pulse: 1'b0,
        line_mode:       LINE_NRZ
    };

    typedef struct packed {
        logic                  en;
        logic [CMD_MEM_AW-1:0] addr;   // word address
        logic [3:0]            strb;
        logic [31:0]           data;
    } mem_wr_t;

    typedef struct packed {
        logic data;
        logic body_first;   // first body bit of a repetition
    } cmd_bit_t;

endpackage

`default_nettype wire

// File: hw/cmd_seq_top.sv
// bus and sequencer share CMD_CLK_IN; a soft reset clears sequencer, encoder and config, not memory
`default_nettype none

module cmd_seq_top
    import cmd_seq_pkg::*;
(
    input  wire               CMD_CLK_IN,
    input  wire               RST_CMD_CLK,
    input  wire [AXIL_AW-1:0] s_axil_awaddr,
    input  wire               s_axil_awvalid,
    output logic              s_axil_awready,
    input  wire [31:0]        s_axil_wdata,
    input  wire [3:0]         s_axil_wstrb,
    input  wire               s_axil_wvalid,
    output logic              s_axil_wready,
    output logic [1:0]        s_axil_bresp,
    output logic              s_axil_bvalid,
    input  wire               s_axil_bready,
    input  wire [AXIL_AW-1:0] s_axil_araddr,
    input  wire               s_axil_arvalid,
    output logic              s_axil_arready,
    output logic [31:0]       s_axil_rdata,
    output logic [1:0]        s_axil_rresp,
    output logic              s_axil_rvalid,
    input  wire               s_axil_rready,
    input  wire               ext_start_flag,
    output logic              cmd_data,
    output logic              cmd_active,
    output logic              cmd_start_flag,
    output logic              cmd_ready,
    output logic              ext_start_enable
);

    seq_conf_t             conf;
    mem_wr_t               mem_wr;
    cmd_bit_t              seq_bit;
    logic                  start_req;
    logic                  soft_rst;
    logic                  seq_rst;
    logic                  busy;
    logic                  bit_valid;
    logic                  bit_ready;
    logic [CMD_MEM_AW-1:0] rd_addr;
    logic [31:0]           rd_data;

    assign seq_rst          = RST_CMD_CLK || soft_rst;
    assign ext_start_enable = conf.en_ext_start;  // for the front end

    cmd_seq_axil_regs i_regs (
        .CMD_CLK_IN     (CMD_CLK_IN),
        .RST_CMD_CLK    (RST_CMD_CLK),
        .s_axil_awaddr  (s_axil_awaddr),
        .s_axil_awvalid (s_axil_awvalid),
        .s_axil_awready (s_axil_awready),
        .s_axil_wdata   (s_axil_wdata),
        .s_axil_wstrb   (s_axil_wstrb),
        .s_axil_wvalid  (s_axil_wvalid),
        .s_axil_wready  (s_axil_wready),
        .s_axil_bresp   (s_axil_bresp),
        .s_axil_bvalid  (s_axil_bvalid),
        .s_axil_bready  (s_axil_bready),
        .s_axil_araddr  (s_axil_araddr),
        .s_axil_arvalid (s_axil_arvalid),
        .s_axil_arready (s_axil_arready),
        .s_axil_rdata   (s_axil_rdata),
        .s_axil_rresp   (s_axil_rresp),
        .s_axil_rvalid  (s_axil_rvalid),
        .s_axil_rready  (s_axil_rready),
        .busy           (busy),
        .conf           (conf),
        .start_req      (start_req),
        .soft_rst       (soft_rst),
        .mem_wr         (mem_wr)
    );

    cmd_seq_mem i_mem (
        .CMD_CLK_IN (CMD_CLK_IN),
        .mem_wr     (mem_wr),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data)
    );

    cmd_seq_ctrl i_ctrl (
        .CMD_CLK_IN     (CMD_CLK_IN),
        .RST_CMD_CLK    (seq_rst),
        .conf           (conf),
        .start_req      (start_req),
        .ext_start_flag (ext_start_flag),
        .rd_data        (rd_data),
        .bit_ready      (bit_ready),
        .rd_addr        (rd_addr),
        .bit_out        (seq_bit),
        .bit_valid      (bit_valid),
        .busy           (busy),
        .cmd_ready      (cmd_ready)
    );

    cmd_line_encoder i_enc (
        .CMD_CLK_IN      (CMD_CLK_IN),
        .RST_CMD_CLK     (seq_rst),
        .line_mode       (conf.line_mode),
        .dis_start_pulse (conf.dis_start_pulse),
        .bit_in          (seq_bit),
        .bit_valid       (bit_valid),
        .bit_ready       (bit_ready),
        .cmd_data        (cmd_data),
        .cmd_active      (cmd_active),
        .cmd_start_flag  (cmd_start_flag)
    );

endmodule

`default_nettype wire

// File: tb/cmd_seq_axil_bfm.svh
// included inside the testbench module; uses its bus signals, lfsr_state, mem_img and run_* lengths
`ifndef CMD_SEQ_AXIL_BFM_SVH
`define CMD_SEQ_AXIL_BFM_SVH

    // 16-bit Galois LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // one LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v          = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    task automatic axil_write(input logic [AXIL_AW-1:0] addr, input logic [31:0] data);
        @(negedge CMD_CLK_IN);
        s_axil_awaddr  = addr;
        s_axil_wdata   = data;
        s_axil_wstrb   = 4'hF;
        s_axil_awvalid = 1'b1;
        s_axil_wvalid  = 1'b1;
        do begin
            @(posedge CMD_CLK_IN);
        end while (!(s_axil_awready && s_axil_wready));
        @(negedge CMD_CLK_IN);
        s_axil_awvalid = 1'b0;
        s_axil_wvalid  = 1'b0;
        while (!s_axil_bvalid)
            @(posedge CMD_CLK_IN);
        assert (s_axil_bresp === AXI_RESP_OKAY)
            else value_fail("s_axil_bresp", s_axil_bresp, AXI_RESP_OKAY);
    endtask

    task automatic axil_read(input logic [AXIL_AW-1:0] addr, output logic [31:0] data,
                             output logic [1:0] resp);
        @(negedge CMD_CLK_IN);
        s_axil_araddr  = addr;
        s_axil_arvalid = 1'b1;
        do begin
            @(posedge CMD_CLK_IN);
        end while (!s_axil_arready);
        @(negedge CMD_CLK_IN);
        s_axil_arvalid = 1'b0;
        while (!s_axil_rvalid)
            @(posedge CMD_CLK_IN);
        data = s_axil_rdata;
        resp = s_axil_rresp;
    endtask

    // bit i sits in byte i/8, MSB first
    task automatic push_model(input int i, input logic first);
        exp_bits.push_back(mem_img[i / 8][7 - (i % 8)]);
        exp_first.push_back(first);
    endtask

    // prefix, body run_repeat times, suffix
    task automatic build_model();
        exp_bits.delete();
        exp_first.delete();
        for (int i = 0; i < run_start; i++) begin
            push_model(i, 1'b0);
        end
        for (int r = 0; r < run_repeat; r++) begin
            for (int i = run_start; i < cmd_size - run_stop; i++) begin
                push_model(i, i == run_start);
            end
        end
        for (int i = cmd_size - run_stop; i < cmd_size; i++) begin
            push_model(i, 1'b0);
        end
    endtask

`endif

// File: tb/cmd_seq_tb.sv
// one run at a time on an 8 ns clock; only the words covering cmd_size bits are written
`default_nettype none

module cmd_seq_tb
    import cmd_seq_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam real CLK_PERIOD   = 8.0;
    localparam int  RST_CYCLES   = 16;
    localparam int  TEST_COUNT   = 6;
    localparam int  SLACK_CYCLES = 200;

    logic               CMD_CLK_IN;
    logic               RST_CMD_CLK;
    logic [AXIL_AW-1:0] s_axil_awaddr;
    logic               s_axil_awvalid;
    logic               s_axil_awready;
    logic [31:0]        s_axil_wdata;
    logic [3:0]         s_axil_wstrb;
    logic               s_axil_wvalid;
    logic               s_axil_wready;
    logic [1:0]         s_axil_bresp;
    logic               s_axil_bvalid;
    logic               s_axil_bready;
    logic [AXIL_AW-1:0] s_axil_araddr;
    logic               s_axil_arvalid;
    logic               s_axil_arready;
    logic [31:0]        s_axil_rdata;
    logic [1:0]         s_axil_rresp;
    logic               s_axil_rvalid;
    logic               s_axil_rready;
    logic               ext_start_flag;
    logic               cmd_data;
    logic               cmd_active;
    logic               cmd_start_flag;
    logic               cmd_ready;
    logic               ext_start_enable;

    logic [7:0]  mem_img [CMD_MEM_BYTES];
    logic [15:0] lfsr_state;
    logic        exp_bits[$];
    logic        exp_first[$];
    logic        cap_data[$];     // one entry per symbol cycle
    logic        cap_flag[$];
    int          cmd_size;
    int          rand_start;
    int          rand_stop;
    int          run_start;
    int          run_stop;
    int          run_repeat;
    longint      watch_cycles = 0;

    cmd_seq_top i_cmd_seq_top (
        .CMD_CLK_IN       (CMD_CLK_IN),
        .RST_CMD_CLK      (RST_CMD_CLK),
        .s_axil_awaddr    (s_axil_awaddr),
        .s_axil_awvalid   (s_axil_awvalid),
        .s_axil_awready   (s_axil_awready),
        .s_axil_wdata     (s_axil_wdata),
        .s_axil_wstrb     (s_axil_wstrb),
        .s_axil_wvalid    (s_axil_wvalid),
        .s_axil_wready    (s_axil_wready),
        .s_axil_bresp     (s_axil_bresp),
        .s_axil_bvalid    (s_axil_bvalid),
        .s_axil_bready    (s_axil_bready),
        .s_axil_araddr    (s_axil_araddr),
        .s_axil_arvalid   (s_axil_arvalid),
        .s_axil_arready   (s_axil_arready),
        .s_axil_rdata     (s_axil_rdata),
        .s_axil_rresp     (s_axil_rresp),
        .s_axil_rvalid    (s_axil_rvalid),
        .s_axil_rready    (s_axil_rready),
        .ext_start_flag   (ext_start_flag),
        .cmd_data         (cmd_data),
        .cmd_active       (cmd_active),
        .cmd_start_flag   (cmd_start_flag),
        .cmd_ready        (cmd_ready),
        .ext_start_enable (ext_start_enable)
    );

    initial begin
        CMD_CLK_IN = 1'b0;
        forever #(CLK_PERIOD / 2) CMD_CLK_IN = !CMD_CLK_IN;
    end

    always @(posedge CMD_CLK_IN) begin
        if (!RST_CMD_CLK && cmd_active) begin
            cap_data.push_back(cmd_data);
            cap_flag.push_back(cmd_start_flag);
        end
    end

    // line idles low, and no ready while symbols go out
    assert property (@(posedge CMD_CLK_IN) disable iff (RST_CMD_CLK)
                     cmd_active || (!cmd_data && !cmd_start_flag))
        else die("cmd_data or cmd_start_flag is high outside a symbol cycle");
    assert property (@(posedge CMD_CLK_IN) disable iff (RST_CMD_CLK)
                     !(cmd_active && cmd_ready))
        else die("cmd_ready is high while cmd_active is high");

    initial begin
        wait (watch_cycles > 0);
        #(watch_cycles * CLK_PERIOD);
        die("watchdog expired, a bus transfer or a run never completed");
    end

    task automatic die(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic value_fail(input string name, input logic [31:0] got, input logic [31:0] exp);
        die($sformatf("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp));
    endtask

    task automatic expect_reg(input logic [AXIL_AW-1:0] addr, input logic [31:0] exp,
                              input logic [1:0] exp_resp, input string name);
        logic [31:0] data;
        logic [1:0]  resp;
        axil_read(addr, data, resp);
        assert (data === exp) else value_fail(name, data, exp);
        assert (resp === exp_resp) else value_fail({name, " rresp"}, resp, exp_resp);
    endtask

    task automatic fill_memory();
        logic [31:0] word;
        for (int w = 0; w < (cmd_size + 31) / 32; w++) begin
            word = rand_bits(32);
            for (int b = 0; b < 4; b++) begin
                mem_img[4 * w + b] = word[8 * b +: 8];   // little endian lanes
            end
            axil_write(MEM_BASE + AXIL_AW'(4 * w), word);
        end
    endtask

    task automatic configure(input logic [31:0] conf_word);
        axil_write(REG_CMD_SIZE, 32'(cmd_size));
        axil_write(REG_REPEAT, 32'(run_repeat));
        axil_write(REG_START_REP, 32'(run_start));
        axil_write(REG_STOP_REP, 32'(run_stop));
        axil_write(REG_CONF, conf_word);
    endtask

    task automatic launch();
        cap_data.delete();
        cap_flag.delete();
        build_model();
        axil_write(REG_CTRL, 32'h1);
    endtask

    task automatic pulse_ext_start();
        @(negedge CMD_CLK_IN);
        ext_start_flag = 1'b1;
        @(negedge CMD_CLK_IN);
        ext_start_flag = 1'b0;
    endtask

    task automatic run_to_end();
        @(posedge CMD_CLK_IN);
        while (cmd_ready)
            @(posedge CMD_CLK_IN);
        while (!cmd_ready)
            @(posedge CMD_CLK_IN);
    endtask

    function automatic logic line_symbol(input line_mode_e mode, input logic b, input int half);
        case (mode)
            LINE_MAN_IEEE:   return (half == 0) ? !b : b;
            LINE_MAN_THOMAS: return (half == 0) ? b : !b;
            default:         return b;
        endcase
    endfunction

    task automatic check_capture(input line_mode_e mode, input logic pulse_on);
        int   spb;
        logic exp_sym;
        logic exp_flag;
        spb = (mode == LINE_MAN_IEEE || mode == LINE_MAN_THOMAS) ? 2 : 1;
        assert (cap_data.size() == exp_bits.size() * spb)
            else value_fail("symbol count", cap_data.size(), exp_bits.size() * spb);
        for (int k = 0; k < cap_data.size(); k++) begin
            exp_sym  = line_symbol(mode, exp_bits[k / spb], k % spb);
            exp_flag = pulse_on && exp_first[k / spb];
            assert (cap_data[k] === exp_sym)
                else value_fail($sformatf("cmd_data[%0d]", k), cap_data[k], exp_sym);
            assert (cap_flag[k] === exp_flag)
                else value_fail($sformatf("cmd_start_flag[%0d]", k), cap_flag[k], exp_flag);
        end
    endtask

    initial begin
        RST_CMD_CLK    = 1'b1;
        s_axil_awaddr  = '0;
        s_axil_awvalid = 1'b0;
        s_axil_wdata   = '0;
        s_axil_wstrb   = '0;
        s_axil_wvalid  = 1'b0;
        s_axil_bready  = 1'b1;
        s_axil_araddr  = '0;
        s_axil_arvalid = 1'b0;
        s_axil_rready  = 1'b1;
        ext_start_flag = 1'b0;
        lfsr_state     = 16'd87;
        cmd_size       = 64 + int'(rand_bits(8));
        rand_start     = 1 + int'(rand_bits(4));
        rand_stop      = 1 + int'(rand_bits(4));

        // NRZ single, NRZ x3 twice more, two Manchester runs, soft reset rerun
        watch_cycles = cmd_size
                       + 8 * (rand_start + rand_stop + 3 * (cmd_size - rand_start - rand_stop))
                       + TEST_COUNT * SLACK_CYCLES;

        repeat (RST_CYCLES) @(posedge CMD_CLK_IN);
        @(negedge CMD_CLK_IN);
        RST_CMD_CLK = 1'b0;

        // 1: reset state and register readback
        assert (cmd_ready === 1'b1) else value_fail("cmd_ready", cmd_ready, 1);
        assert (cmd_active === 1'b0) else value_fail("cmd_active", cmd_active, 0);
        assert (cmd_data === 1'b0) else value_fail("cmd_data", cmd_data, 0);
        assert (cmd_start_flag === 1'b0) else value_fail("cmd_start_flag", cmd_start_flag, 0);
        assert (s_axil_bvalid === 1'b0) else value_fail("s_axil_bvalid", s_axil_bvalid, 0);
        assert (s_axil_rvalid === 1'b0) else value_fail("s_axil_rvalid", s_axil_rvalid, 0);
        expect_reg(REG_CTRL, 32'h1, AXI_RESP_OKAY, "REG_CTRL");
        expect_reg(REG_REPEAT, 32'h1, AXI_RESP_OKAY, "REG_REPEAT");
        axil_write(REG_CONF, 32'h15);            // ext start, IEEE, no pulse
        axil_write(REG_CMD_SIZE, 32'h1234);
        axil_write(REG_REPEAT, 32'hDEADBEEF);
        axil_write(REG_START_REP, 32'h0011);
        axil_write(REG_STOP_REP, 32'h0022);
        expect_reg(REG_CONF, 32'h15, AXI_RESP_OKAY, "REG_CONF");
        expect_reg(REG_CMD_SIZE, 32'h1234, AXI_RESP_OKAY, "REG_CMD_SIZE");
        expect_reg(REG_REPEAT, 32'hDEADBEEF, AXI_RESP_OKAY, "REG_REPEAT");
        expect_reg(REG_START_REP, 32'h0011, AXI_RESP_OKAY, "REG_START_REP");
        expect_reg(REG_STOP_REP, 32'h0022, AXI_RESP_OKAY, "REG_STOP_REP");
        assert (ext_start_enable === 1'b1)
            else value_fail("ext_start_enable", ext_start_enable, 1);
        expect_reg(MEM_BASE, 32'h0, AXI_RESP_OKAY, "memory window");
        expect_reg(13'h0100, 32'h0, AXI_RESP_SLVERR, "unmapped");

        // 2: NRZ single pass
        fill_memory();
        run_start  = 0;
        run_stop   = 0;
        run_repeat = 1;
        configure(32'h0);
        launch();
        run_to_end();
        check_capture(LINE_NRZ, 1'b1);

        // 3: repeated body, finish flag across the run
        run_start  = rand_start;
        run_stop   = rand_stop;
        run_repeat = 3;
        configure(32'h0);
        launch();
        while (!cmd_active)
            @(posedge CMD_CLK_IN);
        expect_reg(REG_CTRL, 32'h0, AXI_RESP_OKAY, "REG_CTRL during run");
        run_to_end();
        expect_reg(REG_CTRL, 32'h1, AXI_RESP_OKAY, "REG_CTRL after run");
        check_capture(LINE_NRZ, 1'b1);

        // 4: Manchester IEEE with pulse, then Thomas without
        axil_write(REG_CONF, 32'h04);
        launch();
        run_to_end();
        check_capture(LINE_MAN_IEEE, 1'b1);
        axil_write(REG_CONF, 32'h16);
        launch();
        run_to_end();
        check_capture(LINE_MAN_THOMAS, 1'b0);

        // 5: external start, masked and then enabled
        axil_write(REG_CONF, 32'h0);
        cap_data.delete();
        cap_flag.delete();
        pulse_ext_start();
        repeat (10) @(posedge CMD_CLK_IN);
        assert (cmd_ready === 1'b1) else value_fail("cmd_ready masked start", cmd_ready, 1);
        assert (cap_data.size() == 0)
            else value_fail("symbols after masked start", cap_data.size(), 0);
        axil_write(REG_CONF, 32'h1);
        build_model();
        pulse_ext_start();
        while (!cmd_active)
            @(posedge CMD_CLK_IN);
        expect_reg(REG_CTRL, 32'h0, AXI_RESP_OKAY, "REG_CTRL during ext run");
        run_to_end();
        check_capture(LINE_NRZ, 1'b1);
        expect_reg(REG_CTRL, 32'h1, AXI_RESP_OKAY, "REG_CTRL after ext run");

        // 6: soft reset in the middle of a run
        axil_write(REG_CONF, 32'h0);
        launch();
        while (!cmd_active)
            @(posedge CMD_CLK_IN);
        repeat (20) @(posedge CMD_CLK_IN);
        axil_write(REG_CTRL, 32'h2);
        repeat (2) @(posedge CMD_CLK_IN);
        assert (cmd_active === 1'b0) else value_fail("cmd_active after soft reset", cmd_active, 0);
        assert (cmd_ready === 1'b1) else value_fail("cmd_ready after soft reset", cmd_ready, 1);
        expect_reg(REG_CTRL, 32'h1, AXI_RESP_OKAY, "REG_CTRL default");
        expect_reg(REG_CONF, 32'h0, AXI_RESP_OKAY, "REG_CONF default");
        expect_reg(REG_CMD_SIZE, 32'h0, AXI_RESP_OKAY, "REG_CMD_SIZE default");
        expect_reg(REG_REPEAT, 32'h1, AXI_RESP_OKAY, "REG_REPEAT default");
        expect_reg(REG_START_REP, 32'h0, AXI_RESP_OKAY, "REG_START_REP default");
        expect_reg(REG_STOP_REP, 32'h0, AXI_RESP_OKAY, "REG_STOP_REP default");
        configure(32'h0);
        launch();
        run_to_end();
        check_capture(LINE_NRZ, 1'b1);

        $display("test passed");
        $finish;
    end

    `include "cmd_seq_axil_bfm.svh"

endmodule

`default_nettype wire
